// File: mem_ctrl_top.f
common/mem_ctrl_pkg.sv
hw/mem_ctrl_fsm/mem_ctrl_fsm.sv
hw/addr_path.sv
hw/write_path.sv
hw/read_path.sv
hw/mem_ctrl_top.sv
testbench/mem_ctrl_sva.sv
testbench/tb_mem_ctrl.sv

// File: testbench/tb_mem_ctrl.sv
// ############################
// // testbench for the memory controller, memory model,
// // shadow memory, reference load model and checks
// ############################
`timescale 1ns/10ps
`default_nettype none

module tb_mem_ctrl
  import mem_ctrl_pkg::*;
();

  localparam int HIST       = 64;   // depth of the expected flag ring
  localparam int WAIT_LIMIT = 20;
  localparam int N_RANDOM   = 200;

  typedef struct packed {
    logic valid;
    logic wready;
    logic busy;
  } flags_t;

  logic     clk;
  logic     reset;
  cpu_req_t cpu_req;
  half_t    mem_rdata;
  mem_req_t mem_req;
  data_t    rdata;
  logic     output_valid;
  logic     write_ready;
  logic     busy;

  half_t  mem [0:(1<<HIDX_W)-1];
  half_t  shadow [0:(1<<HIDX_W)-1];  // memory as the store rules say it should be
  flags_t exp_flags [0:HIST-1];      // expected outputs per cycle
  data_t  exp_q [$];
  int     cyc;
  int     seed;
  int     data_errors;
  int     flag_errors;
  int     timeouts;
  logic   hold_off;  // last request leaves a busy cycle

  mem_ctrl_top i_mem_ctrl_top (
    .clk          (clk),
    .reset        (reset),
    .cpu_req      (cpu_req),
    .mem_rdata    (mem_rdata),
    .mem_req      (mem_req),
    .rdata        (rdata),
    .output_valid (output_valid),
    .write_ready  (write_ready),
    .busy         (busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // synchronous memory, read data one cycle later
  always @(posedge clk) begin
    if (mem_req.read) begin
      mem_rdata <= mem[mem_req.addr];
    end
    if (mem_req.write) begin
      mem[mem_req.addr] <= mem_req.wdata;
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_rdata(input data_t got, input data_t exp);
    if (got !== exp) begin
      data_errors++;
      $display("error at %0t: rdata got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic finish_run;
    int sva_fails;
    sva_fails = i_mem_ctrl_top.u_fsm.u_sva.failures;
    $display("data errors %0d, flag errors %0d, assertion failures %0d, timeouts %0d",
             data_errors, flag_errors, sva_fails, timeouts);
    if (data_errors + flag_errors + sva_fails + timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  // expected rdata from the shadow with big endian lanes
  function automatic data_t expected_load(input addr_t a, input word_type_e t, input logic s);
    hidx_t idx;
    half_t h;
    byte_t b;
    idx = a[ADDR_W-1:1];
    h   = shadow[idx];
    b   = a[0] ? h[BYTE_W-1:0] : h[HALF_W-1:BYTE_W];
    case (t)
      WORD_T:  return {h, shadow[hidx_t'(idx + 16'd1)]};
      HALF_T:  return {{(DATA_W-HALF_W){s & h[HALF_W-1]}}, h};
      default: return {{(DATA_W-BYTE_W){s & b[BYTE_W-1]}}, b};
    endcase
  endfunction

  function automatic void store_shadow(input addr_t a, input word_type_e t, input data_t d);
    hidx_t idx;
    idx = a[ADDR_W-1:1];
    case (t)
      WORD_T: begin
        shadow[idx]                   = d[DATA_W-1:HALF_W];
        shadow[hidx_t'(idx + 16'd1)] = d[HALF_W-1:0];
      end
      HALF_T: shadow[idx] = d[DATA_W-1:HALF_W];
      BYTE_T: begin
        if (a[0]) begin
          shadow[idx][BYTE_W-1:0] = d[BYTE_W-1:0];
        end else begin
          shadow[idx][HALF_W-1:BYTE_W] = d[BYTE_W-1:0];
        end
      end
      default: ;  // illegal type changes nothing
    endcase
  endfunction

  function automatic logic flags_pending();
    logic any;
    any = 1'b0;
    for (int i = 0; i < HIST; i++) begin
      any = any | (|exp_flags[i]);
    end
    return any;
  endfunction

  function automatic cpu_req_t make_req(input logic ld, input word_type_e t, input logic s,
                                        input addr_t a, input data_t d);
    cpu_req_t r;
    r.load      = ld;
    r.store     = !ld;
    r.word_type = t;
    r.is_signed = s;
    r.addr      = a;
    r.wdata     = d;
    return r;
  endfunction

  function automatic cpu_req_t random_req();
    logic [31:0] rnd;
    logic [31:0] d;
    word_type_e  t;
    addr_t       a;
    rnd = $random(seed);
    d   = $random(seed);
    t   = word_type_e'(rnd[1:0] % 2'd3);
    a   = addr_t'(rnd[8:2]);  // small window so loads hit stored data
    if (t == WORD_T) begin
      a[1:0] = 2'b00;
    end else if (t == HALF_T) begin
      a[0] = 1'b0;
    end
    return make_req(rnd[9], t, rnd[10], a, d);
  endfunction

  // drive one request and record what it should produce
  task automatic send_req(input cpu_req_t req);
    int waited;
    int base;
    waited = 0;
    @(posedge clk);
    if (hold_off) begin
      cpu_req.load  <= 1'b0;
      cpu_req.store <= 1'b0;
      @(negedge clk);
      while (!busy && waited < WAIT_LIMIT) begin
        waited++;
        @(negedge clk);
      end
      if (!busy) begin
        stop_on_timeout("busy of a two cycle access");
      end
      @(posedge clk);
    end
    cpu_req  <= req;
    base     = cyc + 2;  // cycle 1 of this request
    hold_off = 1'b0;
    if (req.load) begin
      case (req.word_type)
        WORD_T: begin
          exp_flags[base % HIST].busy        = 1'b1;
          exp_flags[(base + 1) % HIST].valid = 1'b1;
          hold_off = 1'b1;
          exp_q.push_back(expected_load(req.addr, req.word_type, req.is_signed));
        end
        HALF_T, BYTE_T: begin
          exp_flags[base % HIST].valid = 1'b1;
          exp_q.push_back(expected_load(req.addr, req.word_type, req.is_signed));
        end
        default: ;
      endcase
    end else if (req.store) begin
      case (req.word_type)
        HALF_T: exp_flags[base % HIST].wready = 1'b1;
        WORD_T, BYTE_T: begin
          exp_flags[base % HIST].busy         = 1'b1;
          exp_flags[(base + 1) % HIST].wready = 1'b1;
          hold_off = 1'b1;
        end
        default: ;
      endcase
      store_shadow(req.addr, req.word_type, req.wdata);
    end
  endtask

  task automatic wait_drained;
    int waited;
    waited = 0;
    @(posedge clk);
    cpu_req.load  <= 1'b0;
    cpu_req.store <= 1'b0;
    @(negedge clk);
    while ((exp_q.size() != 0 || flags_pending()) && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (exp_q.size() != 0 || flags_pending()) begin
      timeouts++;
      $display("timeout while waiting for outstanding results");
    end
  endtask

  // compare outputs mid cycle
  always @(negedge clk) begin
    if (reset) begin
      check_flag("output_valid", output_valid, exp_flags[cyc % HIST].valid);
      check_flag("write_ready", write_ready, exp_flags[cyc % HIST].wready);
      check_flag("busy", busy, exp_flags[cyc % HIST].busy);
      if (output_valid) begin
        if (exp_q.size() == 0) begin
          data_errors++;
          $display("output_valid was raised at %0t with no load outstanding", $time);
        end else begin
          check_rdata(rdata, exp_q.pop_front());
        end
      end
      exp_flags[cyc % HIST] = '0;
    end
  end

  initial begin
    seed        = 58336;
    cyc         = 0;
    data_errors = 0;
    flag_errors = 0;
    timeouts    = 0;
    hold_off    = 1'b0;
    reset       = 1'b0;
    cpu_req     = '0;
    mem_rdata   = '0;
    for (int i = 0; i < HIST; i++) begin
      exp_flags[i] = '0;
    end
    for (int i = 0; i < (1 << HIDX_W); i++) begin
      mem[i]    = half_t'(i * 40503 + 4660);  // odd multiplier, unique per index
      shadow[i] = mem[i];
    end
    repeat (2) @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);
    check_flag("mem_req.read", mem_req.read, 1'b0);
    check_flag("mem_req.write", mem_req.write, 1'b0);

    for (int s = 0; s < 2; s++) begin
      for (int lane = 0; lane < 2; lane++) begin
        send_req(make_req(1'b1, HALF_T, s[0], addr_t'(32'h12340 + 4 * s), '0));
        send_req(make_req(1'b1, BYTE_T, s[0], addr_t'(32'h12344 + 6 * s + lane), '0));
      end
    end
    send_req(make_req(1'b1, WORD_T, 1'b0, 17'h00100, '0));

    send_req(make_req(1'b0, WORD_T, 1'b0, 17'h00200, 32'h8bad_f00d));
    send_req(make_req(1'b1, WORD_T, 1'b0, 17'h00200, '0));
    send_req(make_req(1'b0, HALF_T, 1'b0, 17'h00210, 32'hc3a5_0000));
    send_req(make_req(1'b1, HALF_T, 1'b1, 17'h00210, '0));
    send_req(make_req(1'b0, BYTE_T, 1'b0, 17'h00220, 32'h0000_0096));
    send_req(make_req(1'b0, BYTE_T, 1'b0, 17'h00223, 32'h0000_0041));
    send_req(make_req(1'b1, HALF_T, 1'b0, 17'h00220, '0));  // other lanes untouched
    send_req(make_req(1'b1, HALF_T, 1'b0, 17'h00222, '0));

    send_req(make_req(1'b1, word_type_e'(2'b11), 1'b0, 17'h00200, '0));
    @(negedge clk);
    check_flag("mem_req.read", mem_req.read, 1'b0);
    check_flag("mem_req.write", mem_req.write, 1'b0);
    send_req(make_req(1'b0, word_type_e'(2'b11), 1'b0, 17'h00200, 32'hffff_ffff));
    @(negedge clk);
    check_flag("mem_req.read", mem_req.read, 1'b0);
    check_flag("mem_req.write", mem_req.write, 1'b0);
    send_req(make_req(1'b1, WORD_T, 1'b0, 17'h00200, '0));

    repeat (N_RANDOM) begin
      send_req(random_req());
    end
    wait_drained();
    finish_run();
  end

endmodule

`default_nettype wire

// File: testbench/mem_ctrl_sva.sv
// ############################
// // concurrent assertions on the FSM request
// // and handshake outputs, bound into the FSM
// ############################
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl_sva (
  input logic clk,
  input logic reset,
  input logic load,
  input logic store,
  input logic output_valid,
  input logic write_ready,
  input logic busy
);

  int failures;  // read by the testbench at the end

  initial begin
    failures = 0;
  end

  property no_req_while_busy;
    @(posedge clk) disable iff (!reset)
      busy |-> !(load || store);
  endproperty

  property valid_and_ready_exclusive;
    @(posedge clk) disable iff (!reset)
      !(output_valid && write_ready);
  endproperty

  // second half of an access never stalls
  property busy_single_cycle;
    @(posedge clk) disable iff (!reset)
      busy |=> !busy;
  endproperty

  assert property (no_req_while_busy)
    else begin
      failures++;
      $error("load or store strobed while busy");
    end

  assert property (valid_and_ready_exclusive)
    else begin
      failures++;
      $error("output_valid and write_ready high together");
    end

  assert property (busy_single_cycle)
    else begin
      failures++;
      $error("busy high for two cycles in a row");
    end

endmodule

bind mem_ctrl_fsm mem_ctrl_sva u_sva (
  .clk          (clk),
  .reset        (reset),
  .load         (load),
  .store        (store),
  .output_valid (output_valid),
  .write_ready  (write_ready),
  .busy         (busy)
);

`default_nettype wire

// File: hw/mem_ctrl_top.sv
// ############################
// // memory controller top level, FSM and
// // address, write and read datapaths
// ############################
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl_top
  import mem_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  cpu_req_t cpu_req,
  input  half_t    mem_rdata,
  output mem_req_t mem_req,
  output data_t    rdata,
  output logic     output_valid,
  output logic     write_ready,
  output logic     busy
);

  mem_ctrl_t ctrl;
  hidx_t     mem_addr;
  half_t     mem_wdata;
  logic      byte_lane;  // captured address bit 0

  mem_ctrl_fsm u_fsm (
    .clk          (clk),
    .reset        (reset),
    .load         (cpu_req.load),
    .store        (cpu_req.store),
    .word_type    (cpu_req.word_type),
    .is_signed    (cpu_req.is_signed),
    .ctrl         (ctrl),
    .output_valid (output_valid),
    .write_ready  (write_ready),
    .busy         (busy)
  );

  addr_path u_addr_path (
    .clk       (clk),
    .reset     (reset),
    .addr      (cpu_req.addr),
    .ctrl      (ctrl),
    .mem_addr  (mem_addr),
    .byte_lane (byte_lane)
  );

  write_path u_write_path (
    .clk       (clk),
    .reset     (reset),
    .wdata     (cpu_req.wdata),
    .mem_rdata (mem_rdata),
    .byte_lane (byte_lane),
    .ctrl      (ctrl),
    .mem_wdata (mem_wdata)
  );

  read_path u_read_path (
    .clk       (clk),
    .reset     (reset),
    .mem_rdata (mem_rdata),
    .byte_lane (byte_lane),
    .ctrl      (ctrl),
    .rdata     (rdata)
  );

  assign mem_req.read  = ctrl.mem_read;
  assign mem_req.write = ctrl.mem_write;
  assign mem_req.addr  = mem_addr;
  assign mem_req.wdata = mem_wdata;

endmodule

`default_nettype wire

// File: hw/read_path.sv
// ############################
// // read datapath, halfword delay,
// // word assembly and sign or zero extension
// ############################
`timescale 1ns/10ps
`default_nettype none

module read_path
  import mem_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  half_t     mem_rdata,
  input  logic      byte_lane,
  input  mem_ctrl_t ctrl,
  output data_t     rdata
);

  half_t prev_half;  // halfword from the cycle before
  byte_t lane_byte;
  logic  half_sign;
  logic  byte_sign;

  always_ff @(posedge clk) begin
    if (!reset) begin
      prev_half <= '0;
    end else begin
      prev_half <= mem_rdata;
    end
  end

  // lane 0 is the upper byte in big endian order
  always_comb begin
    if (byte_lane) begin
      lane_byte = mem_rdata[BYTE_W-1:0];
    end else begin
      lane_byte = mem_rdata[HALF_W-1:BYTE_W];
    end
  end

  assign half_sign = mem_rdata[HALF_W-1];
  assign byte_sign = lane_byte[BYTE_W-1];

  always_comb begin
    case (ctrl.out_sel)
      OUT_WORD: begin
        rdata = {prev_half, mem_rdata};  // top half read one cycle earlier
      end
      OUT_HALF_S: begin
        rdata = {{(DATA_W-HALF_W){half_sign}}, mem_rdata};
      end
      OUT_HALF_U: begin
        rdata = {{(DATA_W-HALF_W){1'b0}}, mem_rdata};
      end
      OUT_BYTE_S: begin
        rdata = {{(DATA_W-BYTE_W){byte_sign}}, lane_byte};
      end
      OUT_BYTE_U: begin
        rdata = {{(DATA_W-BYTE_W){1'b0}}, lane_byte};
      end
      default: begin
        rdata = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/write_path.sv
// ############################
// // write datapath, store data capture,
// // halfword select and byte merge
// ############################
`timescale 1ns/10ps
`default_nettype none

module write_path
  import mem_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  data_t     wdata,
  input  half_t     mem_rdata,
  input  logic      byte_lane,
  input  mem_ctrl_t ctrl,
  output half_t     mem_wdata
);

  half_t low_q;     // low half of the store data
  byte_t new_byte;
  half_t merged;

  always_ff @(posedge clk) begin
    if (!reset) begin
      low_q <= '0;
    end else if (ctrl.capture) begin
      low_q <= wdata[HALF_W-1:0];
    end
  end

  assign new_byte = low_q[BYTE_W-1:0];

  // old halfword arrives this cycle from the read issued on accept
  always_comb begin
    if (byte_lane) begin
      merged = {mem_rdata[HALF_W-1:BYTE_W], new_byte};
    end else begin
      merged = {new_byte, mem_rdata[BYTE_W-1:0]};
    end
  end

  always_comb begin
    case (ctrl.wdata_sel)
      WD_DIRECT_TOP:  mem_wdata = wdata[DATA_W-1:HALF_W];
      WD_DELAYED_LOW: mem_wdata = low_q;
      WD_MERGED:      mem_wdata = merged;
      default:        mem_wdata = wdata[DATA_W-1:HALF_W];
    endcase
  end

endmodule

`default_nettype wire

// File: hw/addr_path.sv
// ############################
// // address datapath, index capture
// // and memory address select
// ############################
`timescale 1ns/10ps
`default_nettype none

module addr_path
  import mem_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  addr_t     addr,
  input  mem_ctrl_t ctrl,
  output hidx_t     mem_addr,
  output logic      byte_lane
);

  hidx_t req_idx;   // halfword index of incoming request
  hidx_t idx_q;
  hidx_t next_idx;  // low half of a word
  logic  lane_q;

  assign req_idx = addr[ADDR_W-1:1];

  always_ff @(posedge clk) begin
    if (!reset) begin
      idx_q  <= '0;
      lane_q <= 1'b0;
    end else if (ctrl.capture) begin
      idx_q  <= req_idx;
      lane_q <= addr[0];
    end
  end

  assign next_idx = idx_q + hidx_t'(1);

  always_comb begin
    case (ctrl.addr_sel)
      ADDR_ORIGINAL: mem_addr = req_idx;
      ADDR_NEXT:     mem_addr = next_idx;
      ADDR_DELAYED:  mem_addr = idx_q;
      default:       mem_addr = req_idx;
    endcase
  end

  assign byte_lane = lane_q;  // 0 selects bits 15:8

endmodule

`default_nettype wire

// File: hw/mem_ctrl_fsm/mem_ctrl_fsm.sv
// ############################
// // control FSM, state register, request dispatch
// // and control word decode per state
// ############################
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl_fsm
  import mem_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       load,
  input  logic       store,
  input  word_type_e word_type,
  input  logic       is_signed,
  output mem_ctrl_t  ctrl,
  output logic       output_valid,
  output logic       write_ready,
  output logic       busy
);

  typedef enum logic [3:0] {
    IDLE         = 4'b0000,
    LOAD_HW      = 4'b0001,
    LOAD_BYTE    = 4'b0010,
    LOAD_WORD_A  = 4'b0011,
    LOAD_WORD_B  = 4'b0100,
    STORE_HW     = 4'b1111,
    STORE_BYTE_A = 4'b1011,
    STORE_BYTE_B = 4'b1010,
    STORE_WORD_A = 4'b1101,
    STORE_WORD_B = 4'b1100
  } state_e;

  // state plus sign of the accepted load
  typedef struct packed {
    state_e st;
    logic   sign;
  } fsm_reg_t;

  fsm_reg_t  cur;
  fsm_reg_t  nxt;
  state_e    disp_state;  // target of a new request
  mem_ctrl_t disp_ctrl;   // control word for a new request

  always_ff @(posedge clk) begin
    if (!reset) begin
      cur.st   <= IDLE;
      cur.sign <= 1'b0;
    end else begin
      cur <= nxt;
    end
  end

  // shared dispatch, used in every state except the A states
  always_comb begin
    disp_state = IDLE;
    disp_ctrl  = CTRL_IDLE;
    if (load) begin
      case (word_type)
        WORD_T:  disp_state = LOAD_WORD_A;
        HALF_T:  disp_state = LOAD_HW;
        BYTE_T:  disp_state = LOAD_BYTE;
        default: disp_state = IDLE;  // illegal type, no access
      endcase
      disp_ctrl.mem_read = (disp_state != IDLE);
    end else if (store) begin
      case (word_type)
        WORD_T: begin
          disp_state          = STORE_WORD_A;
          disp_ctrl.mem_write = 1'b1;  // top half first
        end
        HALF_T: begin
          disp_state          = STORE_HW;
          disp_ctrl.mem_write = 1'b1;
        end
        BYTE_T: begin
          disp_state         = STORE_BYTE_A;
          disp_ctrl.mem_read = 1'b1;  // fetch old halfword
        end
        default: disp_state = IDLE;
      endcase
    end
    disp_ctrl.capture = (disp_state != IDLE);
  end

  always_comb begin
    nxt.st       = disp_state;
    ctrl         = disp_ctrl;
    output_valid = 1'b0;
    write_ready  = 1'b0;
    busy         = 1'b0;
    case (cur.st)
      LOAD_HW: begin
        output_valid = 1'b1;
        ctrl.out_sel = cur.sign ? OUT_HALF_S : OUT_HALF_U;
      end
      LOAD_BYTE: begin
        output_valid = 1'b1;
        ctrl.out_sel = cur.sign ? OUT_BYTE_S : OUT_BYTE_U;
      end
      LOAD_WORD_A: begin
        nxt.st        = LOAD_WORD_B;
        ctrl          = CTRL_IDLE;
        ctrl.mem_read = 1'b1;
        ctrl.addr_sel = ADDR_NEXT;  // low half
        busy          = 1'b1;
      end
      LOAD_WORD_B: begin
        output_valid = 1'b1;
        ctrl.out_sel = OUT_WORD;
      end
      STORE_HW: begin
        write_ready = 1'b1;
      end
      STORE_WORD_A: begin
        nxt.st         = STORE_WORD_B;
        ctrl           = CTRL_IDLE;
        ctrl.mem_write = 1'b1;
        ctrl.addr_sel  = ADDR_NEXT;
        ctrl.wdata_sel = WD_DELAYED_LOW;
        busy           = 1'b1;
      end
      STORE_WORD_B: begin
        write_ready = 1'b1;
      end
      STORE_BYTE_A: begin
        nxt.st         = STORE_BYTE_B;
        ctrl           = CTRL_IDLE;
        ctrl.mem_write = 1'b1;
        ctrl.addr_sel  = ADDR_DELAYED;  // same halfword as the read
        ctrl.wdata_sel = WD_MERGED;
        busy           = 1'b1;
      end
      STORE_BYTE_B: begin
        write_ready = 1'b1;
      end
      default: begin
      end
    endcase
    // sign kept for the load accepted this cycle
    nxt.sign = ctrl.capture ? is_signed : cur.sign;
  end

endmodule

`default_nettype wire

// File: common/mem_ctrl_pkg.sv
// ############################
// // widths, enums, request and control word structs
// // shared by the memory controller and its testbench
// ############################
`default_nettype none

package mem_ctrl_pkg;

  localparam int DATA_W = 32;  // cpu side
  localparam int HALF_W = 16;  // memory word
  localparam int BYTE_W = 8;
  localparam int ADDR_W = 17;  // byte address
  localparam int HIDX_W = 16;  // halfword index

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [HALF_W-1:0] half_t;
  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [HIDX_W-1:0] hidx_t;

  // access size where code 2'b11 is illegal and ignored
  typedef enum logic [1:0] {
    BYTE_T = 2'b00,
    HALF_T = 2'b01,
    WORD_T = 2'b10
  } word_type_e;

  typedef enum logic [1:0] {
    ADDR_ORIGINAL = 2'd0,  // index of incoming request
    ADDR_NEXT     = 2'd1,  // captured index + 1
    ADDR_DELAYED  = 2'd2   // captured index
  } addr_sel_e;

  // halfword stores write data bits 31:16, byte stores insert bits 7:0
  typedef enum logic [1:0] {
    WD_DIRECT_TOP  = 2'd0,
    WD_DELAYED_LOW = 2'd1,
    WD_MERGED      = 2'd2
  } wdata_sel_e;

  typedef enum logic [2:0] {
    OUT_WORD   = 3'd0,
    OUT_HALF_S = 3'd1,
    OUT_HALF_U = 3'd2,
    OUT_BYTE_S = 3'd3,
    OUT_BYTE_U = 3'd4
  } out_sel_e;

  typedef struct packed {
    logic       load;
    logic       store;
    word_type_e word_type;
    logic       is_signed;
    addr_t      addr;
    data_t      wdata;
  } cpu_req_t;

  typedef struct packed {
    logic  read;
    logic  write;
    hidx_t addr;
    half_t wdata;
  } mem_req_t;

  // control word from the FSM to the datapaths
  typedef struct packed {
    logic       mem_read;
    logic       mem_write;
    logic       capture;  // latch request address and data
    addr_sel_e  addr_sel;
    wdata_sel_e wdata_sel;
    out_sel_e   out_sel;
  } mem_ctrl_t;

  localparam mem_ctrl_t CTRL_IDLE = '{
    mem_read:  1'b0,
    mem_write: 1'b0,
    capture:   1'b0,
    addr_sel:  ADDR_ORIGINAL,
    wdata_sel: WD_DIRECT_TOP,
    out_sel:   OUT_WORD
  };

endpackage

`default_nettype wire
